/* logic/fetch_pkg.sv */
package fetch_pkg;

    // instruction and memory widths
    localparam int WORD_W = 32;
    localparam int BEAT_W = 64;
    localparam int LINE_W = 256;

    // line geometry
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int OFFSET_BITS = 5;
    localparam int WORD_SEL_BITS = 3;

    // byte address
    typedef logic [31:0] addr_t;

    // one instruction
    typedef logic [WORD_W-1:0] word_t;

    // one memory beat
    typedef logic [BEAT_W-1:0] beat_t;

    // one full line
    typedef logic [LINE_W-1:0] line_t;

    // line address, upper bits of a byte address
    typedef logic [31-OFFSET_BITS:0] tag_t;

    // running instruction sequence number
    typedef logic [63:0] order_t;

    // entry held in the instruction queue, 128 bits
    typedef struct packed {
        order_t order;
        addr_t  pc;
        word_t  inst;
    } fetch_entry_t;

endpackage

/* logic/line_fill.sv */
module line_fill (
    input  logic              clk,
    input  logic              rst,
    input  logic              fill_req_i,
    input  fetch_pkg::addr_t  fill_addr_i,
    output fetch_pkg::addr_t  bmem_addr_o,
    output logic              bmem_read_o,
    input  logic              bmem_ready_i,
    input  fetch_pkg::addr_t  bmem_raddr_i,
    input  fetch_pkg::beat_t  bmem_rdata_i,
    input  logic              bmem_rvalid_i,
    output logic              fill_done_o,
    output fetch_pkg::line_t  fill_line_o,
    output fetch_pkg::addr_t  fill_line_addr_o
);
    import fetch_pkg::*;

    localparam int BEAT_IDX_W = $clog2(BEATS_PER_LINE);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_COLLECT
    } state_t;

    state_t                  state;
    logic [BEAT_IDX_W-1:0]   beat_cnt;
    logic [BEAT_IDX_W-1:0]   beat_idx;
    tag_t                    line_tag;
    line_t                   line_q;

    // position of the returning beat inside the line
    assign beat_idx = bmem_raddr_i[OFFSET_BITS-1 -: BEAT_IDX_W];

    assign bmem_read_o = (state == ST_REQUEST);
    assign bmem_addr_o = {line_tag, {OFFSET_BITS{1'b0}}};
    assign fill_line_addr_o = {line_tag, {OFFSET_BITS{1'b0}}};
    assign fill_line_o = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            beat_cnt <= '0;
            fill_done_o <= 1'b0;
        end else begin
            fill_done_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // requests while busy are not looked at
                    if (fill_req_i) begin
                        state <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (bmem_ready_i) begin
                        state <= ST_COLLECT;
                        beat_cnt <= '0;
                    end
                end
                ST_COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == BEAT_IDX_W'(BEATS_PER_LINE - 1)) begin
                            state <= ST_IDLE;
                            fill_done_o <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // line address and beat data
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && fill_req_i) begin
            line_tag <= fill_addr_i[31:OFFSET_BITS];
        end
        if (state == ST_COLLECT && bmem_rvalid_i) begin
            line_q[beat_idx*BEAT_W +: BEAT_W] <= bmem_rdata_i;
        end
    end

endmodule

/* logic/line_buffer.sv */
module line_buffer (
    input  logic              clk,
    input  logic              rst,
    input  fetch_pkg::addr_t  pc_i,
    input  logic              fill_done_i,
    input  fetch_pkg::addr_t  fill_addr_i,
    input  fetch_pkg::line_t  fill_line_i,
    output logic              hit_o,
    output fetch_pkg::word_t  word_o
);
    import fetch_pkg::*;

    logic                      valid_q;
    tag_t                      tag_q;
    line_t                     line_q;
    tag_t                      pc_tag;
    logic [WORD_SEL_BITS-1:0]  word_sel;
    word_t                     words [WORDS_PER_LINE];

    assign pc_tag = pc_i[31:OFFSET_BITS];
    assign word_sel = pc_i[OFFSET_BITS-1 -: WORD_SEL_BITS];

    // valid bit set by the first fill
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fill_done_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            tag_q <= fill_addr_i[31:OFFSET_BITS];
            line_q <= fill_line_i;
        end
    end

    // split the line into instruction words
    always_comb begin
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            words[i] = line_q[i*WORD_W +: WORD_W];
        end
    end

    assign hit_o = valid_q && (tag_q == pc_tag);
    assign word_o = words[word_sel];

endmodule

/* logic/fetch_ctrl.sv */
module fetch_ctrl #(
    parameter fetch_pkg::addr_t RESET_PC = 32'haaaaa000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     redirect_i,
    input  fetch_pkg::addr_t         redirect_pc_i,
    input  logic                     hit_i,
    input  fetch_pkg::word_t         word_i,
    input  logic                     fill_done_i,
    input  logic                     full_i,
    output fetch_pkg::addr_t         pc_o,
    output logic                     fill_req_o,
    output fetch_pkg::addr_t         fill_addr_o,
    output logic                     enq_o,
    output fetch_pkg::fetch_entry_t  entry_o,
    output logic                     flush_o
);
    import fetch_pkg::*;

    addr_t   pc;
    order_t  order;
    logic    fill_pending;
    logic    miss;

    assign pc_o = pc;

    // redirect empties the queue in the same cycle
    assign flush_o = redirect_i;

    // one instruction per cycle while the buffer hits
    assign enq_o = hit_i && !full_i && !redirect_i;

    assign entry_o.order = order;
    assign entry_o.pc = pc;
    assign entry_o.inst = word_i;

    // at most one fill in flight, redirects let it finish
    assign miss = !hit_i && !fill_pending && !redirect_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            order <= '0;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else if (enq_o) begin
            pc <= pc + 32'd4;
            order <= order + 64'd1;
        end
    end

    // fill request follows the miss by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_req_o <= 1'b0;
            fill_pending <= 1'b0;
        end else begin
            fill_req_o <= miss;
            if (miss) begin
                fill_pending <= 1'b1;
            end else if (fill_done_i) begin
                fill_pending <= 1'b0;
            end
        end
    end

    // line aligned address of the missing pc
    always_ff @(posedge clk) begin
        if (miss) begin
            fill_addr_o <= {pc[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
    end

endmodule

/* logic/inst_queue.sv */
module inst_queue #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush_i,
    input  logic                     enq_i,
    input  fetch_pkg::fetch_entry_t  entry_i,
    output logic                     full_o,
    output logic                     valid_o,
    input  logic                     ready_i,
    output fetch_pkg::word_t         inst_o,
    output fetch_pkg::addr_t         pc_o,
    output fetch_pkg::order_t        order_o
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    fetch_entry_t      mem [DEPTH];
    fetch_entry_t      head;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_enq;
    logic              do_deq;

    assign full_o = (count == (PTR_W + 1)'(DEPTH));
    assign valid_o = (count != '0);

    assign do_enq = enq_i && !full_o && !flush_i;
    assign do_deq = valid_o && ready_i && !flush_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count unchanged
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    // head entry out as loose fields
    assign head = mem[rd_ptr];
    assign inst_o = head.inst;
    assign pc_o = head.pc;
    assign order_o = head.order;

endmodule

/* logic/fetch_frontend.sv */
module fetch_frontend #(
    parameter fetch_pkg::addr_t RESET_PC = 32'haaaaa000,
    parameter int QUEUE_DEPTH = 32
) (
    input  logic               clk,
    input  logic               rst,

    output fetch_pkg::addr_t   bmem_addr_o,
    output logic               bmem_read_o,
    input  logic               bmem_ready_i,
    input  fetch_pkg::addr_t   bmem_raddr_i,
    input  fetch_pkg::beat_t   bmem_rdata_i,
    input  logic               bmem_rvalid_i,

    input  logic               redirect_i,
    input  fetch_pkg::addr_t   redirect_pc_i,

    output logic               inst_valid_o,
    input  logic               inst_ready_i,
    output fetch_pkg::word_t   inst_o,
    output fetch_pkg::addr_t   inst_pc_o,
    output fetch_pkg::order_t  inst_order_o
);
    import fetch_pkg::*;

    addr_t         pc;
    logic          hit;
    word_t         word;
    logic          fill_req;
    addr_t         fill_addr;
    logic          fill_done;
    line_t         fill_line;
    addr_t         fill_line_addr;
    logic          enq;
    fetch_entry_t  entry;
    logic          full;
    logic          flush;

    fetch_ctrl #(
        .RESET_PC       (RESET_PC)
    ) u_fetch_ctrl (
        .clk            (clk),
        .rst            (rst),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .hit_i          (hit),
        .word_i         (word),
        .fill_done_i    (fill_done),
        .full_i         (full),
        .pc_o           (pc),
        .fill_req_o     (fill_req),
        .fill_addr_o    (fill_addr),
        .enq_o          (enq),
        .entry_o        (entry),
        .flush_o        (flush)
    );

    // single level, the last filled line
    line_buffer u_line_buffer (
        .clk            (clk),
        .rst            (rst),
        .pc_i           (pc),
        .fill_done_i    (fill_done),
        .fill_addr_i    (fill_line_addr),
        .fill_line_i    (fill_line),
        .hit_o          (hit),
        .word_o         (word)
    );

    line_fill u_line_fill (
        .clk              (clk),
        .rst              (rst),
        .fill_req_i       (fill_req),
        .fill_addr_i      (fill_addr),
        .bmem_addr_o      (bmem_addr_o),
        .bmem_read_o      (bmem_read_o),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_raddr_i     (bmem_raddr_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_rvalid_i    (bmem_rvalid_i),
        .fill_done_o      (fill_done),
        .fill_line_o      (fill_line),
        .fill_line_addr_o (fill_line_addr)
    );

    inst_queue #(
        .DEPTH          (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush),
        .enq_i          (enq),
        .entry_i        (entry),
        .full_o         (full),
        .valid_o        (inst_valid_o),
        .ready_i        (inst_ready_i),
        .inst_o         (inst_o),
        .pc_o           (inst_pc_o),
        .order_o        (inst_order_o)
    );

endmodule

/* verification/burst_mem_model.sv */
module burst_mem_model #(
    parameter logic [31:0] DATA_KEY = 32'h13570000
) (
    input  logic              clk,
    input  logic              rst,
    input  fetch_pkg::addr_t  addr_i,
    input  logic              read_i,
    output logic              ready_o,
    output fetch_pkg::addr_t  raddr_o,
    output fetch_pkg::beat_t  rdata_o,
    output logic              rvalid_o,
    output int                beats_owed_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    logic   read_q;
    logic   ready_q;
    addr_t  addr_q;
    addr_t  base;
    int     beat_idx;

    // two words per beat, lower address in the low half
    function automatic beat_t beat_at(input addr_t a);
        return {(a + 32'd4) ^ DATA_KEY, a ^ DATA_KEY};
    endfunction

    initial begin
        ready_o = 1'b0;
        raddr_o = '0;
        rdata_o = '0;
        rvalid_o = 1'b0;
        beats_owed_o = 0;
        read_q = 1'b0;
        ready_q = 1'b0;
        addr_q = '0;
        base = '0;
        beat_idx = 0;
    end

    // outputs change only on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            ready_o = 1'b0;
            rvalid_o = 1'b0;
            beats_owed_o = 0;
            read_q = 1'b0;
            ready_q = 1'b0;
        end else begin
            // request taken at the rising edge just passed
            if (read_q && ready_q) begin
                beats_owed_o = BEATS_PER_LINE;
                base = addr_q;
                beat_idx = 0;
            end
            if (beats_owed_o > 0 && $urandom_range(0, 2) != 0) begin
                rvalid_o = 1'b1;
                raddr_o = base + 32'(8 * beat_idx);
                rdata_o = beat_at(raddr_o);
                beat_idx = beat_idx + 1;
                beats_owed_o = beats_owed_o - 1;
            end else begin
                rvalid_o = 1'b0;
            end
            ready_o = ($urandom_range(0, 3) != 0);
            read_q = read_i;
            ready_q = ready_o;
            addr_q = addr_i;
        end
    end

endmodule

/* verification/tb_fetch_frontend.sv */
module tb_fetch_frontend;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    localparam addr_t RESET_PC = 32'haaaaa000;
    localparam logic [31:0] DATA_KEY = 32'h13570000;
    localparam int SEQ_N = 200;
    localparam int RAND_N = 600;
    localparam int DIRECTED_N = 20;
    localparam int TOTAL_N = SEQ_N + DIRECTED_N + RAND_N;

    logic clk;
    logic rst;
    logic redirect_i;
    addr_t redirect_pc_i;
    logic inst_ready_i;
    logic inst_valid_o;
    word_t inst_o;
    addr_t inst_pc_o;
    order_t inst_order_o;
    addr_t bmem_addr_o;
    logic bmem_read_o;
    logic bmem_ready_i;
    addr_t bmem_raddr_i;
    beat_t bmem_rdata_i;
    logic bmem_rvalid_i;
    int beats_owed;

    int errors;
    int accepted;
    addr_t exp_pc;
    order_t last_order;
    logic any_accepted;
    logic redirected;
    logic expect_no_read;
    logic run_valid;
    addr_t last_req_line;
    logic prev_valid;
    logic prev_ready;
    logic prev_redirect;
    word_t prev_inst;
    addr_t prev_pc;
    order_t prev_order;
    logic prev_read;
    logic prev_rdy;
    addr_t prev_addr;
    logic rst_prev;

    fetch_frontend #(
        .RESET_PC       (RESET_PC),
        .QUEUE_DEPTH    (32)
    ) u_fetch_frontend (
        .clk            (clk),
        .rst            (rst),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_raddr_i   (bmem_raddr_i),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .inst_valid_o   (inst_valid_o),
        .inst_ready_i   (inst_ready_i),
        .inst_o         (inst_o),
        .inst_pc_o      (inst_pc_o),
        .inst_order_o   (inst_order_o)
    );

    burst_mem_model #(
        .DATA_KEY       (DATA_KEY)
    ) u_mem (
        .clk            (clk),
        .rst            (rst),
        .addr_i         (bmem_addr_o),
        .read_i         (bmem_read_o),
        .ready_o        (bmem_ready_i),
        .raddr_o        (bmem_raddr_i),
        .rdata_o        (bmem_rdata_i),
        .rvalid_o       (bmem_rvalid_i),
        .beats_owed_o   (beats_owed)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic report_error(input string msg);
        errors = errors + 1;
        $display("** Error @ %0t: %s", $time, msg);
    endtask

    task automatic wait_accepted(input int n);
        while (accepted < n) begin
            @(negedge clk);
        end
    endtask

    // stalled on a full queue once no read shows for a while
    task automatic wait_mem_quiet();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < 40 && waited < 4000) begin
            @(negedge clk);
            #1;
            if (bmem_read_o || beats_owed != 0) begin
                quiet = 0;
            end else begin
                quiet = quiet + 1;
            end
            waited = waited + 1;
        end
        if (quiet < 40) begin
            errors = errors + 1;
            $display("memory side never went idle with the decode side stalled");
        end
    endtask

    // checks run between the falling edge and the next rising edge
    always begin
        @(negedge clk);
        #1;
        if (rst || rst_prev) begin
            assert (!inst_valid_o && !bmem_read_o)
                else report_error("valid or read high during reset");
        end
        if (!rst) begin
            if (prev_read && !prev_rdy) begin
                assert (bmem_read_o && bmem_addr_o == prev_addr)
                    else report_error("read request changed while waiting for ready");
            end
            if (bmem_read_o) begin
                assert (bmem_addr_o[4:0] == 5'd0)
                    else report_error($sformatf("unaligned read 0x%08h", bmem_addr_o));
                assert (beats_owed == 0)
                    else report_error("read request while beats still owed");
                assert (!expect_no_read)
                    else report_error("read after redirect into the last filled line");
                if (bmem_ready_i) begin
                    if (run_valid) begin
                        assert (bmem_addr_o != last_req_line)
                            else report_error($sformatf("line 0x%08h read twice",
                                bmem_addr_o));
                    end
                    last_req_line = bmem_addr_o;
                    run_valid = 1'b1;
                end
            end
            if (prev_valid && !prev_ready && !prev_redirect) begin
                assert (inst_valid_o && inst_o == prev_inst && inst_pc_o == prev_pc
                        && inst_order_o == prev_order)
                    else report_error("decode outputs moved while not ready");
            end
            if (redirect_i) begin
                exp_pc = redirect_pc_i;
                redirected = 1'b1;
                run_valid = 1'b0;
            end else if (inst_valid_o && inst_ready_i) begin
                assert (inst_o == (inst_pc_o ^ DATA_KEY))
                    else report_error($sformatf("pc 0x%08h inst 0x%08h", inst_pc_o, inst_o));
                assert (inst_pc_o == exp_pc)
                    else report_error($sformatf("pc 0x%08h expected 0x%08h",
                        inst_pc_o, exp_pc));
                if (!any_accepted && !redirected) begin
                    assert (inst_order_o == 64'd0)
                        else report_error("first order not zero");
                    last_order = 64'd0;
                end else if (!redirected) begin
                    assert (inst_order_o == last_order + 64'd1)
                        else report_error($sformatf("order %0d after %0d",
                            inst_order_o, last_order));
                    last_order = last_order + 64'd1;
                end else begin
                    if (any_accepted) begin
                        assert (inst_order_o > last_order)
                            else report_error("order not increasing after redirect");
                    end
                    // after a redirect the order is only bounded below
                    last_order = inst_order_o;
                end
                exp_pc = exp_pc + 32'd4;
                any_accepted = 1'b1;
                redirected = 1'b0;
                expect_no_read = 1'b0;
                accepted = accepted + 1;
            end
        end
        prev_valid = inst_valid_o;
        prev_ready = inst_ready_i;
        prev_redirect = redirect_i;
        prev_inst = inst_o;
        prev_pc = inst_pc_o;
        prev_order = inst_order_o;
        prev_read = bmem_read_o;
        prev_rdy = bmem_ready_i;
        prev_addr = bmem_addr_o;
        rst_prev = rst;
    end

    // run time limit from the test lengths
    initial begin
        #(real'(TOTAL_N * 200 + 1000) * 4.0);
        $display("timeout, the fetch stream stopped before all tests ended");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'h1d71));
        errors = 0;
        accepted = 0;
        exp_pc = RESET_PC;
        last_order = '0;
        any_accepted = 1'b0;
        redirected = 1'b0;
        expect_no_read = 1'b0;
        run_valid = 1'b0;
        last_req_line = '0;
        prev_valid = 1'b0;
        prev_ready = 1'b0;
        prev_redirect = 1'b0;
        prev_read = 1'b0;
        prev_rdy = 1'b0;
        rst_prev = 1'b1;
        rst = 1'b1;
        redirect_i = 1'b0;
        redirect_pc_i = '0;
        inst_ready_i = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // straight run from the reset pc
        inst_ready_i = 1'b1;
        wait_accepted(SEQ_N);

        // redirect into the line the buffer holds
        inst_ready_i = 1'b0;
        wait_mem_quiet();
        @(negedge clk);
        redirect_i = 1'b1;
        redirect_pc_i = last_req_line + 32'(4 * $urandom_range(0, 7));
        expect_no_read = 1'b1;
        @(negedge clk);
        redirect_i = 1'b0;
        inst_ready_i = 1'b1;
        wait_accepted(SEQ_N + DIRECTED_N);

        // random back-pressure and redirects
        while (accepted < TOTAL_N) begin
            @(negedge clk);
            inst_ready_i = ($urandom_range(0, 2) != 0);
            if ($urandom_range(0, 63) == 0) begin
                redirect_i = 1'b1;
                redirect_pc_i = 32'h00100000 | ($urandom & 32'h000ffffc);
            end else begin
                redirect_i = 1'b0;
            end
        end
        @(negedge clk);
        redirect_i = 1'b0;
        repeat (2) @(negedge clk);

        $display("accepted %0d instructions, %0d errors", accepted, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* all.f */
logic/fetch_pkg.sv
logic/line_fill.sv
logic/line_buffer.sv
logic/fetch_ctrl.sv
logic/inst_queue.sv
logic/fetch_frontend.sv
verification/burst_mem_model.sv
verification/tb_fetch_frontend.sv

/* Makefile */
SIM := obj_dir/Vtb_fetch_frontend
SRCS := $(shell grep -v '^+' all.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_fetch_frontend -f all.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
